// File: Makefile
TOP = tb_layer_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: src/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	typedef enum logic [1:0] {
		OKAY  = 2'b00,
		ERROR = 2'b01
	} hresp_t;

	// Address phase inputs sampled together
	typedef struct packed {
		logic        sel;
		logic [31:0] addr;
		logic        write;
		logic [2:0]  size;
		htrans_t     trans;
		logic        ready;
	} ahb_req_t;

endpackage

`default_nettype wire

// File: src/ahb_slave_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc_defines.svh"

module ahb_slave_regs (
	input  wire                 HCLK,
	input  wire                 HRESETn,
	input  ahb_pkg::ahb_req_t   ahb,
	input  wire [31:0]          HWDATA,
	output logic [31:0]         HRDATA,
	output logic                HREADYOUT,
	output ahb_pkg::hresp_t     HRESP,
	output logic                tx_push,
	output lc_pkg::msg_t        tx_push_msg,
	input  lc_pkg::fifo_stat_t  tx_stat,
	output logic                rx_pop,
	input  lc_pkg::msg_t        rx_head,
	input  lc_pkg::fifo_stat_t  rx_stat,
	input  wire                 tx_succ_evt,
	input  wire                 tx_fail_evt,
	input  wire                 frame_evt,
	output logic [2:0]          sticky
);

	localparam int STAT_W = $bits(lc_pkg::lc_status_t);

	logic                      take;
	logic                      dp_valid;
	logic                      dp_write;
	logic [7:0]                dp_addr;
	logic                      wr_en;
	logic                      rd_en;
	logic [`LC_ADDR_WIDTH-1:0] tx_addr_q;
	logic                      succ_q;
	logic                      fail_q;
	logic                      frame_q;
	logic                      status_wr;
	lc_pkg::lc_status_t        status;
	lc_pkg::lc_status_t        wr_status;

	assign take = ahb.sel && ahb.ready &&
		(ahb.trans == ahb_pkg::NONSEQ || ahb.trans == ahb_pkg::SEQ);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			dp_valid <= 1'b0;
		else if (ahb.ready)
			dp_valid <= take;
	end

	always_ff @(posedge HCLK)
	begin
		if (take)
		begin
			dp_write <= ahb.write;
			dp_addr  <= ahb.addr[7:0];
		end
	end

	assign wr_en = dp_valid && dp_write;
	assign rd_en = dp_valid && !dp_write;

	// Writes land at the end of the data phase, when HWDATA is valid
	always_ff @(posedge HCLK)
	begin
		if (wr_en && dp_addr == `LC_REG_TX_ADDR)
			tx_addr_q <= HWDATA;
	end

	assign tx_push          = wr_en && (dp_addr == `LC_REG_TX_DATA) && !tx_stat.full;
	assign tx_push_msg.addr = tx_addr_q;
	assign tx_push_msg.data = HWDATA;

	assign rx_pop = rd_en && (dp_addr == `LC_REG_RX_DATA) && !rx_stat.empty;

	assign status_wr = wr_en && (dp_addr == `LC_REG_STATUS);
	assign wr_status = lc_pkg::lc_status_t'(HWDATA[STAT_W-1:0]);

	// A new event wins over a write-one clear in the same cycle
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			succ_q  <= 1'b0;
			fail_q  <= 1'b0;
			frame_q <= 1'b0;
		end
		else
		begin
			if (tx_succ_evt)
				succ_q <= 1'b1;
			else if (status_wr && wr_status.tx_succ)
				succ_q <= 1'b0;
			if (tx_fail_evt)
				fail_q <= 1'b1;
			else if (status_wr && wr_status.tx_fail)
				fail_q <= 1'b0;
			if (frame_evt)
				frame_q <= 1'b1;
			else if (status_wr && wr_status.frame_complete)
				frame_q <= 1'b0;
		end
	end

	assign sticky = {succ_q, fail_q, frame_q};

	assign status.tx_empty       = tx_stat.empty;
	assign status.tx_full        = tx_stat.full;
	assign status.rx_empty       = rx_stat.empty;
	assign status.rx_full        = rx_stat.full;
	assign status.tx_succ        = succ_q;
	assign status.tx_fail        = fail_q;
	assign status.frame_complete = frame_q;

	always_comb
	begin
		HRDATA = '0;
		if (rd_en)
		begin
			case (dp_addr)
				`LC_REG_RX_ADDR: HRDATA = rx_stat.empty ? '0 : rx_head.addr;
				`LC_REG_RX_DATA: HRDATA = rx_stat.empty ? '0 : rx_head.data;
				`LC_REG_STATUS:  HRDATA = {{(32-STAT_W){1'b0}}, status};
				default:         HRDATA = '0;
			endcase
		end
	end

	// Zero wait states and no error responses
	assign HREADYOUT = 1'b1;
	assign HRESP     = ahb_pkg::OKAY;

endmodule

`default_nettype wire

// File: src/layer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module layer_ctrl (
	input  wire                HCLK,
	input  wire                HRESETn,
	input  lc_pkg::msg_t       tx_head,
	input  lc_pkg::msg_t       tx_next,
	input  lc_pkg::fifo_stat_t tx_stat,
	output logic               tx_pop,
	output logic               tx_flush,
	output lc_pkg::msg_t       tx_msg,
	output logic               tx_pend,
	output logic               tx_req,
	input  wire                tx_ack,
	input  wire                tx_succ,
	input  wire                tx_fail,
	output logic               tx_resp_ack,
	input  wire                rx_req,
	input  wire                rx_pend,
	output logic               rx_ack,
	input  lc_pkg::fifo_stat_t rx_stat,
	output logic               rx_push,
	output logic               tx_succ_evt,
	output logic               tx_fail_evt,
	output logic               frame_complete
);

	typedef enum logic {
		TX_IDLE,
		TX_WAIT
	} tx_state_t;

	typedef enum logic {
		RX_IDLE,
		RX_WAIT
	} rx_state_t;

	tx_state_t tx_state;
	rx_state_t rx_state;

	// TX_WAIT is the request phase of the handshake
	assign tx_req = (tx_state == TX_WAIT);
	assign tx_msg = tx_head;

	// The node keeps the frame open while the next entry shares the address
	assign tx_pend = !tx_stat.next_empty && (tx_next.addr == tx_head.addr);

	// The tail moves on the same edge that drops the request
	assign tx_pop = (tx_state == TX_WAIT) && tx_ack && !tx_stat.empty;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			tx_state <= TX_IDLE;
		else
		begin
			case (tx_state)
				TX_IDLE:
				begin
					if (!tx_stat.empty && !tx_ack)
						tx_state <= TX_WAIT;
				end
				TX_WAIT:
				begin
					if (tx_ack)
						tx_state <= TX_IDLE;
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// Response pair follows the OR of the two response lines
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			tx_resp_ack <= 1'b0;
		else
			tx_resp_ack <= tx_succ || tx_fail;
	end

	// Each response is counted once, before its acknowledge rises
	assign tx_succ_evt = tx_succ && !tx_resp_ack;
	assign tx_fail_evt = tx_fail && !tx_resp_ack;
	assign tx_flush    = tx_fail_evt;

	assign rx_ack  = (rx_state == RX_WAIT);
	assign rx_push = (rx_state == RX_IDLE) && rx_req && !rx_stat.full;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			rx_state       <= RX_IDLE;
			frame_complete <= 1'b0;
		end
		else
		begin
			frame_complete <= rx_push && !rx_pend;
			case (rx_state)
				RX_IDLE:
				begin
					if (rx_push)
						rx_state <= RX_WAIT;
				end
				RX_WAIT:
				begin
					if (!rx_req)
						rx_state <= RX_IDLE;
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// The node acknowledges only a pending request
	a_ack_needs_req: assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(tx_ack) |-> tx_req);

endmodule

`default_nettype wire

// File: src/layer_top.sv
`timescale 1ns/1ns
`default_nettype none

module layer_top (
	input  wire               HCLK,
	input  wire               HRESETn,
	input  wire               HSEL,
	input  wire [31:0]        HADDR,
	input  wire               HWRITE,
	input  wire [2:0]         HSIZE,
	input  wire [2:0]         HBURST,
	input  wire [3:0]         HPROT,
	input  wire [1:0]         HTRANS,
	input  wire               HMASTLOCK,
	input  wire               HREADY,
	input  wire [31:0]        HWDATA,
	output logic              HREADYOUT,
	output ahb_pkg::hresp_t   HRESP,
	output logic [31:0]       HRDATA,
	output lc_pkg::msg_t      tx_msg,
	output logic              tx_pend,
	output logic              tx_req,
	input  wire               tx_ack,
	input  wire               tx_succ,
	input  wire               tx_fail,
	output logic              tx_resp_ack,
	input  lc_pkg::msg_t      rx_msg,
	input  wire               rx_pend,
	input  wire               rx_req,
	output logic              rx_ack,
	output logic              frame_complete
);

	ahb_pkg::ahb_req_t  ahb_req;
	logic               tx_push;
	lc_pkg::msg_t       tx_push_msg;
	logic               tx_pop;
	logic               tx_flush;
	lc_pkg::msg_t       tx_head;
	lc_pkg::msg_t       tx_next;
	lc_pkg::fifo_stat_t tx_stat;
	logic               rx_push;
	logic               rx_pop;
	lc_pkg::msg_t       rx_head;
	lc_pkg::fifo_stat_t rx_stat;
	logic               tx_succ_evt;
	logic               tx_fail_evt;

	// HBURST, HPROT and HMASTLOCK carry nothing this slave needs
	assign ahb_req.sel   = HSEL;
	assign ahb_req.addr  = HADDR;
	assign ahb_req.write = HWRITE;
	assign ahb_req.size  = HSIZE;
	assign ahb_req.trans = ahb_pkg::htrans_t'(HTRANS);
	assign ahb_req.ready = HREADY;

	ahb_slave_regs u_regs (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.ahb         (ahb_req),
		.HWDATA      (HWDATA),
		.HRDATA      (HRDATA),
		.HREADYOUT   (HREADYOUT),
		.HRESP       (HRESP),
		.tx_push     (tx_push),
		.tx_push_msg (tx_push_msg),
		.tx_stat     (tx_stat),
		.rx_pop      (rx_pop),
		.rx_head     (rx_head),
		.rx_stat     (rx_stat),
		.tx_succ_evt (tx_succ_evt),
		.tx_fail_evt (tx_fail_evt),
		.frame_evt   (frame_complete),
		.sticky      ()
	);

	layer_ctrl u_ctrl (
		.HCLK           (HCLK),
		.HRESETn        (HRESETn),
		.tx_head        (tx_head),
		.tx_next        (tx_next),
		.tx_stat        (tx_stat),
		.tx_pop         (tx_pop),
		.tx_flush       (tx_flush),
		.tx_msg         (tx_msg),
		.tx_pend        (tx_pend),
		.tx_req         (tx_req),
		.tx_ack         (tx_ack),
		.tx_succ        (tx_succ),
		.tx_fail        (tx_fail),
		.tx_resp_ack    (tx_resp_ack),
		.rx_req         (rx_req),
		.rx_pend        (rx_pend),
		.rx_ack         (rx_ack),
		.rx_stat        (rx_stat),
		.rx_push        (rx_push),
		.tx_succ_evt    (tx_succ_evt),
		.tx_fail_evt    (tx_fail_evt),
		.frame_complete (frame_complete)
	);

	msg_fifo u_tx_fifo (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.push     (tx_push),
		.push_msg (tx_push_msg),
		.pop      (tx_pop),
		.flush    (tx_flush),
		.head_msg (tx_head),
		.next_msg (tx_next),
		.stat     (tx_stat)
	);

	// The receive side is never flushed and only its head is read
	msg_fifo u_rx_fifo (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.push     (rx_push),
		.push_msg (rx_msg),
		.pop      (rx_pop),
		.flush    (1'b0),
		.head_msg (rx_head),
		.next_msg (),
		.stat     (rx_stat)
	);

endmodule

`default_nettype wire

// File: src/lc_defines.svh
`ifndef LC_DEFINES_SVH
`define LC_DEFINES_SVH

// Entries per message FIFO, one of them always kept spare
`define LC_FIFO_DEPTH 8

`define LC_ADDR_WIDTH 32
`define LC_DATA_WIDTH 32

// Byte offsets within the slave's window
`define LC_REG_TX_ADDR 8'h00
`define LC_REG_TX_DATA 8'h04
`define LC_REG_RX_ADDR 8'h08
`define LC_REG_RX_DATA 8'h0C
`define LC_REG_STATUS  8'h10

`endif

// File: src/lc_pkg.sv
`default_nettype none

`include "lc_defines.svh"

package lc_pkg;

	typedef struct packed {
		logic [`LC_ADDR_WIDTH-1:0] addr;
		logic [`LC_DATA_WIDTH-1:0] data;
	} msg_t;

	// next_empty means at most one entry is stored
	typedef struct packed {
		logic empty;
		logic full;
		logic next_empty;
	} fifo_stat_t;

	// Low bits of STATUS, frame_complete in bit 0
	typedef struct packed {
		logic tx_empty;
		logic tx_full;
		logic rx_empty;
		logic rx_full;
		logic tx_succ;
		logic tx_fail;
		logic frame_complete;
	} lc_status_t;

endpackage

`default_nettype wire

// File: src/msg_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc_defines.svh"

module msg_fifo (
	input  wire              HCLK,
	input  wire              HRESETn,
	input  wire              push,
	input  lc_pkg::msg_t     push_msg,
	input  wire              pop,
	input  wire              flush,
	output lc_pkg::msg_t     head_msg,
	output lc_pkg::msg_t     next_msg,
	output lc_pkg::fifo_stat_t stat
);

	localparam int PTR_W = $clog2(`LC_FIFO_DEPTH);

	lc_pkg::msg_t     mem [`LC_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_nx;
	logic [PTR_W-1:0] rd_ptr_nx;

	function automatic logic [PTR_W-1:0] inc_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`LC_FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign wr_ptr_nx = inc_ptr(wr_ptr);
	assign rd_ptr_nx = inc_ptr(rd_ptr);

	assign head_msg = mem[rd_ptr];
	assign next_msg = mem[rd_ptr_nx];

	// One slot stays unused so that full and empty differ
	assign stat.empty      = (wr_ptr == rd_ptr);
	assign stat.full       = (wr_ptr_nx == rd_ptr);
	assign stat.next_empty = stat.empty || (rd_ptr_nx == wr_ptr);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push && !stat.full)
				wr_ptr <= wr_ptr_nx;
			// A flush drops everything stored before this edge
			if (flush)
				rd_ptr <= wr_ptr;
			else if (pop && !stat.empty)
				rd_ptr <= rd_ptr_nx;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push && !stat.full)
			mem[wr_ptr] <= push_msg;
	end

	// Callers gate their strobes with the status flags
	a_no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
		push |-> !stat.full);
	a_no_pop_empty: assert property (@(posedge HCLK) disable iff (!HRESETn)
		pop |-> !stat.empty);

endmodule

`default_nettype wire

// File: tb/tb_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc_defines.svh"

module tb_layer_top;

	localparam int TIMEOUT_CYCLES = 2000;

	// STATUS bit positions, frame_complete in bit 0
	localparam int ST_TX_EMPTY = 6;
	localparam int ST_TX_FULL  = 5;
	localparam int ST_RX_EMPTY = 4;
	localparam int ST_RX_FULL  = 3;
	localparam int ST_TX_SUCC  = 2;
	localparam int ST_TX_FAIL  = 1;
	localparam int ST_FRAME    = 0;
	localparam logic [31:0] ST_IDLE = (32'h1 << ST_TX_EMPTY) | (32'h1 << ST_RX_EMPTY);

	logic            HCLK;
	logic            HRESETn;
	logic            HSEL;
	logic [31:0]     HADDR;
	logic            HWRITE;
	logic [2:0]      HSIZE;
	logic [2:0]      HBURST;
	logic [3:0]      HPROT;
	logic [1:0]      HTRANS;
	logic            HMASTLOCK;
	logic            HREADY;
	logic [31:0]     HWDATA;
	logic            HREADYOUT;
	ahb_pkg::hresp_t HRESP;
	logic [31:0]     HRDATA;
	lc_pkg::msg_t    tx_msg;
	logic            tx_pend;
	logic            tx_req;
	logic            tx_ack;
	logic            tx_succ;
	logic            tx_fail;
	logic            tx_resp_ack;
	lc_pkg::msg_t    rx_msg;
	logic            rx_pend;
	logic            rx_req;
	logic            rx_ack;
	logic            frame_complete;

	int errors;
	int cycles;
	int frame_pulses;

	layer_top u_dut (
		.HCLK           (HCLK),
		.HRESETn        (HRESETn),
		.HSEL           (HSEL),
		.HADDR          (HADDR),
		.HWRITE         (HWRITE),
		.HSIZE          (HSIZE),
		.HBURST         (HBURST),
		.HPROT          (HPROT),
		.HTRANS         (HTRANS),
		.HMASTLOCK      (HMASTLOCK),
		.HREADY         (HREADY),
		.HWDATA         (HWDATA),
		.HREADYOUT      (HREADYOUT),
		.HRESP          (HRESP),
		.HRDATA         (HRDATA),
		.tx_msg         (tx_msg),
		.tx_pend        (tx_pend),
		.tx_req         (tx_req),
		.tx_ack         (tx_ack),
		.tx_succ        (tx_succ),
		.tx_fail        (tx_fail),
		.tx_resp_ack    (tx_resp_ack),
		.rx_msg         (rx_msg),
		.rx_pend        (rx_pend),
		.rx_req         (rx_req),
		.rx_ack         (rx_ack),
		.frame_complete (frame_complete)
	);

	always #50 HCLK = ~HCLK;

	always @(posedge HCLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles (%0d errors so far)",
				cycles, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Counts cycles with frame_complete high, so a clean pulse adds one
	always @(negedge HCLK)
	begin
		if (frame_complete === 1'b1)
			frame_pulses++;
	end

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Fail at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
	endtask

	// Every task starts and ends 1 ns after a rising edge
	task automatic ahb_write(input logic [7:0] off, input logic [31:0] data);
		HSEL   = 1'b1;
		HADDR  = {24'h0, off};
		HWRITE = 1'b1;
		HTRANS = 2'b10;
		@(posedge HCLK);
		#1;
		HSEL   = 1'b0;
		HWRITE = 1'b0;
		HTRANS = 2'b00;
		HWDATA = data;
		@(posedge HCLK);
		#1;
	endtask

	task automatic ahb_read(input logic [7:0] off, output logic [31:0] data);
		HSEL   = 1'b1;
		HADDR  = {24'h0, off};
		HWRITE = 1'b0;
		HTRANS = 2'b10;
		@(posedge HCLK);
		#1;
		HSEL   = 1'b0;
		HTRANS = 2'b00;
		@(negedge HCLK);
		data = HRDATA;
		if ({HREADYOUT, HRESP} !== 3'b100)
			report_mismatch("HREADYOUT and HRESP", {29'h0, HREADYOUT, HRESP}, 32'h4);
		@(posedge HCLK);
		#1;
	endtask

	// Plays the node taking one message; keep_ack leaves tx_ack high on return
	task automatic node_accept_tx(output lc_pkg::msg_t msg, output logic pend,
		input logic keep_ack);
		while (tx_req !== 1'b1)
		begin
			@(posedge HCLK);
			#1;
		end
		msg    = tx_msg;
		pend   = tx_pend;
		tx_ack = 1'b1;
		@(posedge HCLK);
		#1;
		if (tx_req !== 1'b0)
			report_mismatch("tx_req one cycle after tx_ack", tx_req, 0);
		if (!keep_ack)
		begin
			tx_ack = 1'b0;
			@(posedge HCLK);
			#1;
		end
	endtask

	task automatic node_respond(input logic fail);
		if (fail)
			tx_fail = 1'b1;
		else
			tx_succ = 1'b1;
		@(posedge HCLK);
		#1;
		if (tx_resp_ack !== 1'b1)
			report_mismatch("tx_resp_ack after response", tx_resp_ack, 1);
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		@(posedge HCLK);
		#1;
		if (tx_resp_ack !== 1'b0)
			report_mismatch("tx_resp_ack after response drop", tx_resp_ack, 0);
	endtask

	task automatic node_send_rx(input lc_pkg::msg_t msg, input logic pend);
		rx_msg  = msg;
		rx_pend = pend;
		rx_req  = 1'b1;
		while (rx_ack !== 1'b1)
		begin
			@(posedge HCLK);
			#1;
		end
		rx_req = 1'b0;
		@(posedge HCLK);
		#1;
		if (rx_ack !== 1'b0)
			report_mismatch("rx_ack one cycle after rx_req fell", rx_ack, 0);
	endtask

	task automatic test_reset();
		logic [31:0] rd;
		if ({tx_req, rx_ack, tx_resp_ack, frame_complete} !== 4'b0000)
			report_mismatch("node outputs after reset",
				{tx_req, rx_ack, tx_resp_ack, frame_complete}, 0);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ST_IDLE)
			report_mismatch("STATUS after reset", rd, ST_IDLE);
	endtask

	task automatic test_tx_order();
		lc_pkg::msg_t sent [3];
		lc_pkg::msg_t got;
		logic         pend;
		logic [2:0]   exp_pend;
		logic [31:0]  rd;
		// Only the first of the same-address pair has a follower with its address
		exp_pend     = 3'b001;
		sent[0].addr = 32'h0000_0A10;
		sent[1].addr = 32'h0000_0A10;
		sent[2].addr = 32'h0000_0B20;
		for (int i = 0; i < 3; i++)
		begin
			sent[i].data = $urandom;
			ahb_write(`LC_REG_TX_ADDR, sent[i].addr);
			ahb_write(`LC_REG_TX_DATA, sent[i].data);
		end
		for (int i = 0; i < 3; i++)
		begin
			node_accept_tx(got, pend, 1'b0);
			if (got !== sent[i])
				report_mismatch("tx_msg data in order", got.data, sent[i].data);
			if (pend !== exp_pend[i])
				report_mismatch("tx_pend", pend, exp_pend[i]);
		end
		node_respond(1'b0);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== (ST_IDLE | (32'h1 << ST_TX_SUCC)))
			report_mismatch("STATUS after tx_succ", rd, ST_IDLE | (32'h1 << ST_TX_SUCC));
		ahb_write(`LC_REG_STATUS, 32'h1 << ST_TX_SUCC);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ST_IDLE)
			report_mismatch("STATUS after tx_succ clear", rd, ST_IDLE);
	endtask

	task automatic test_tx_fail();
		lc_pkg::msg_t sent [3];
		lc_pkg::msg_t got;
		logic         pend;
		logic [31:0]  rd;
		for (int i = 0; i < 3; i++)
		begin
			sent[i].addr = 32'h0000_0C00 + 32'(i) * 4;
			sent[i].data = $urandom;
			ahb_write(`LC_REG_TX_ADDR, sent[i].addr);
			ahb_write(`LC_REG_TX_DATA, sent[i].data);
		end
		// The node reports failure before it releases tx_ack
		node_accept_tx(got, pend, 1'b1);
		if (got !== sent[0])
			report_mismatch("first message before failure", got.data, sent[0].data);
		node_respond(1'b1);
		tx_ack = 1'b0;
		repeat (10)
		begin
			@(posedge HCLK);
			#1;
			if (tx_req !== 1'b0)
				report_mismatch("tx_req after flush", tx_req, 0);
		end
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== (ST_IDLE | (32'h1 << ST_TX_FAIL)))
			report_mismatch("STATUS after tx_fail", rd, ST_IDLE | (32'h1 << ST_TX_FAIL));
		ahb_write(`LC_REG_STATUS, 32'h1 << ST_TX_FAIL);
	endtask

	task automatic test_rx_frame();
		lc_pkg::msg_t words [3];
		int           pulses_before;
		logic [31:0]  rd;
		pulses_before = frame_pulses;
		for (int i = 0; i < 3; i++)
		begin
			words[i].addr = 32'h0000_0E00 + 32'(i);
			words[i].data = $urandom;
			node_send_rx(words[i], i != 2);
		end
		if (frame_pulses - pulses_before != 1)
			report_mismatch("frame_complete cycles", frame_pulses - pulses_before, 1);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ((32'h1 << ST_TX_EMPTY) | (32'h1 << ST_FRAME)))
			report_mismatch("STATUS after frame", rd,
				(32'h1 << ST_TX_EMPTY) | (32'h1 << ST_FRAME));
		ahb_write(`LC_REG_STATUS, 32'h1 << ST_FRAME);
		for (int i = 0; i < 3; i++)
		begin
			ahb_read(`LC_REG_RX_ADDR, rd);
			if (rd !== words[i].addr)
				report_mismatch("RX_ADDR", rd, words[i].addr);
			ahb_read(`LC_REG_RX_DATA, rd);
			if (rd !== words[i].data)
				report_mismatch("RX_DATA", rd, words[i].data);
		end
		ahb_read(`LC_REG_RX_DATA, rd);
		if (rd !== 32'h0)
			report_mismatch("RX_DATA on empty FIFO", rd, 0);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ST_IDLE)
			report_mismatch("STATUS after frame read back", rd, ST_IDLE);
	endtask

	task automatic test_rx_backpressure();
		lc_pkg::msg_t words [9];
		logic [31:0]  rd;
		for (int i = 0; i < 9; i++)
		begin
			words[i].addr = 32'h0000_0100 + 32'(i);
			words[i].data = $urandom;
		end
		// Seven words fill the FIFO, one slot stays spare
		for (int i = 0; i < 7; i++)
			node_send_rx(words[i], 1'b1);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ((32'h1 << ST_TX_EMPTY) | (32'h1 << ST_RX_FULL)))
			report_mismatch("STATUS with RX FIFO full", rd,
				(32'h1 << ST_TX_EMPTY) | (32'h1 << ST_RX_FULL));
		for (int i = 7; i < 9; i++)
		begin
			rx_msg  = words[i];
			rx_pend = (i != 8);
			rx_req  = 1'b1;
			repeat (5)
			begin
				@(posedge HCLK);
				#1;
				if (rx_ack !== 1'b0)
					report_mismatch("rx_ack while RX FIFO full", rx_ack, 0);
			end
			ahb_read(`LC_REG_RX_ADDR, rd);
			if (rd !== words[i-7].addr)
				report_mismatch("RX_ADDR under back-pressure", rd, words[i-7].addr);
			ahb_read(`LC_REG_RX_DATA, rd);
			if (rd !== words[i-7].data)
				report_mismatch("RX_DATA under back-pressure", rd, words[i-7].data);
			while (rx_ack !== 1'b1)
			begin
				@(posedge HCLK);
				#1;
			end
			rx_req = 1'b0;
			@(posedge HCLK);
			#1;
		end
		for (int i = 2; i < 9; i++)
		begin
			ahb_read(`LC_REG_RX_ADDR, rd);
			if (rd !== words[i].addr)
				report_mismatch("RX_ADDR after back-pressure", rd, words[i].addr);
			ahb_read(`LC_REG_RX_DATA, rd);
			if (rd !== words[i].data)
				report_mismatch("RX_DATA after back-pressure", rd, words[i].data);
		end
		ahb_write(`LC_REG_STATUS, 32'h1 << ST_FRAME);
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ST_IDLE)
			report_mismatch("STATUS after back-pressure", rd, ST_IDLE);
	endtask

	task automatic test_tx_overflow();
		lc_pkg::msg_t sent [11];
		lc_pkg::msg_t got;
		logic         pend;
		logic [31:0]  rd;
		for (int i = 0; i < 11; i++)
		begin
			sent[i].addr = 32'h0000_0D00 + 32'(i) * 4;
			sent[i].data = $urandom;
			ahb_write(`LC_REG_TX_ADDR, sent[i].addr);
			ahb_write(`LC_REG_TX_DATA, sent[i].data);
		end
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ((32'h1 << ST_TX_FULL) | (32'h1 << ST_RX_EMPTY)))
			report_mismatch("STATUS with TX FIFO full", rd,
				(32'h1 << ST_TX_FULL) | (32'h1 << ST_RX_EMPTY));
		for (int i = 0; i < 7; i++)
		begin
			node_accept_tx(got, pend, 1'b0);
			if (got.addr !== sent[i].addr)
				report_mismatch("tx_msg address after overflow", got.addr, sent[i].addr);
			if (got.data !== sent[i].data)
				report_mismatch("tx_msg data after overflow", got.data, sent[i].data);
			if (pend !== 1'b0)
				report_mismatch("tx_pend with distinct addresses", pend, 0);
		end
		repeat (5)
		begin
			@(posedge HCLK);
			#1;
			if (tx_req !== 1'b0)
				report_mismatch("tx_req after the seventh message", tx_req, 0);
		end
		ahb_read(`LC_REG_STATUS, rd);
		if (rd !== ST_IDLE)
			report_mismatch("STATUS after overflow drain", rd, ST_IDLE);
	endtask

	initial
	begin
		void'($urandom(13));
		errors       = 0;
		cycles       = 0;
		frame_pulses = 0;
		HCLK         = 1'b0;
		HRESETn      = 1'b0;
		HSEL         = 1'b0;
		HADDR        = 32'h0;
		HWRITE       = 1'b0;
		HSIZE        = 3'b010;
		HBURST       = 3'b000;
		HPROT        = 4'b0011;
		HTRANS       = 2'b00;
		HMASTLOCK    = 1'b0;
		HREADY       = 1'b1;
		HWDATA       = 32'h0;
		tx_ack       = 1'b0;
		tx_succ      = 1'b0;
		tx_fail      = 1'b0;
		rx_msg       = '0;
		rx_pend      = 1'b0;
		rx_req       = 1'b0;
		repeat (8) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		test_reset();
		test_tx_order();
		test_tx_fail();
		test_rx_frame();
		test_rx_backpressure();
		test_tx_overflow();

		$display("Finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/ahb_pkg.sv
src/lc_pkg.sv
src/msg_fifo.sv
src/ahb_slave_regs.sv
src/layer_ctrl.sv
src/layer_top.sv
tb/tb_layer_top.sv
